/* Bender.yml */
package:
  name: frame_buffer

sources:
  - verilog/frame_pkg.sv
  - verilog/axis_if.sv
  - verilog/frame_len_check.sv
  - verilog/frame_store.sv
  - verilog/frame_stats.sv
  - verilog/frame_buffer_top.sv
  - target: simulation
    files:
      - tb/frame_store_props.sv
      - tb/frame_scoreboard.sv
      - tb/frame_buffer_tb.sv

/* compile.f */
verilog/frame_pkg.sv
verilog/axis_if.sv
verilog/frame_len_check.sv
verilog/frame_store.sv
verilog/frame_stats.sv
verilog/frame_buffer_top.sv
tb/frame_store_props.sv
tb/frame_scoreboard.sv
tb/frame_buffer_tb.sv

/* tb/frame_buffer_tb.sv */
// frame buffer testbench; random lengths avoid 62 to 66 beats, where store fill is ambiguous
`timescale 1ns/10ps

module frame_buffer_tb
    import frame_pkg::*;
();

    typedef enum {CLS_GOOD, CLS_BAD, CLS_DROP} frame_class_t;

    localparam logic [31:0] SEED = 32'hcdb6;
    localparam int T1_FRAMES = 12;
    localparam int T2_ERR_FRAMES = 4;
    localparam int T5_FRAMES = 30;
    // upper bound of all input beats, tests 1 to 5 in order
    localparam int TEST_BEATS = T1_FRAMES * MAX_FRAME_LEN + T2_ERR_FRAMES * MAX_FRAME_LEN
                              + 1 + 60 + 70 + 80 + T5_FRAMES * 72;
    localparam int WATCHDOG_CYCLES = TEST_BEATS * 4 + 1000;

    logic                  clk;
    logic                  rst;
    logic [DATA_WIDTH-1:0] in_tdata;
    logic                  in_tvalid;
    logic                  in_tready;
    logic                  in_tlast;
    logic                  in_tuser;
    logic [DATA_WIDTH-1:0] out_tdata;
    logic                  out_tvalid;
    logic                  out_tready;
    logic                  out_tlast;
    logic [STAT_WIDTH-1:0] good_frames;
    logic [STAT_WIDTH-1:0] bad_frames;
    logic [STAT_WIDTH-1:0] dropped_frames;

    logic [31:0] data_seed;
    // separate stream for ready toggling
    logic [31:0] rdy_seed;
    logic        ready_random;
    int          exp_good;
    int          exp_bad;
    int          exp_drop;
    int          test_num;
    int          err_mark;

    frame_buffer_top dut_i (.*);

    frame_scoreboard scb_i (.*);

    bind frame_store frame_store_props props_i (
        .clk          (clk),
        .rst          (rst),
        .out_tdata    (out_tdata),
        .out_tvalid   (out_tvalid),
        .out_tready   (out_tready),
        .out_tlast    (out_tlast),
        .frame_commit (frame_commit),
        .frame_reject (frame_reject),
        .frame_drop   (frame_drop),
        .wr_ptr       (wr_ptr)
    );

    always #5 clk = ~clk;

    // random output back-pressure, test 5 only
    always @(posedge clk) begin
        #1;
        if (ready_random) begin
            rdy_seed = next_rand(rdy_seed);
            out_tready = rdy_seed[17];
        end
    end

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // scoreboard mismatches plus failed store assertions
    function automatic int error_total();
        return scb_i.err_count + dut_i.store_i.props_i.fail_count;
    endfunction

    // held = words of committed frames still in the store
    function automatic frame_class_t expected_class(input int len, input bit err, input int held);
        // any frame that cannot fit is dropped before its length is judged
        if (len + held > FIFO_DEPTH) begin
            return CLS_DROP;
        end
        if (err || len < MIN_FRAME_LEN || len > MAX_FRAME_LEN) begin
            return CLS_BAD;
        end
        return CLS_GOOD;
    endfunction

    // ends 1 ns after a rising edge, where all driving happens
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drive_beat(input logic [7:0] data, input bit last, input bit user);
        in_tdata  = data;
        in_tvalid = 1'b1;
        in_tlast  = last;
        in_tuser  = user;
        while (!in_tready) begin
            wait_cycles(1);
        end
        wait_cycles(1);
    endtask

    task automatic run_frame(input int len, input bit err, input int held);
        frame_class_t cls;
        logic [7:0]   data;
        cls = expected_class(len, err, held);
        case (cls)
            CLS_GOOD: exp_good++;
            CLS_BAD:  exp_bad++;
            default:  exp_drop++;
        endcase
        for (int i = 0; i < len; i++) begin
            data_seed = next_rand(data_seed);
            data = data_seed[23:16];
            if (cls == CLS_GOOD) begin
                scb_i.exp_q.push_back({i == len - 1, data});
            end
            // error flag on the last beat only
            drive_beat(data, i == len - 1, err && i == len - 1);
        end
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        in_tuser  = 1'b0;
    endtask

    // drain expected output, let counters settle, then report
    task automatic finish_test(input string name);
        int errs;
        while (scb_i.exp_q.size() != 0) begin
            wait_cycles(1);
        end
        // checker stage plus stats register
        wait_cycles(4);
        scb_i.check_counters(exp_good, exp_bad, exp_drop);
        errs = error_total() - err_mark;
        err_mark = error_total();
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, errs);
    endtask

    initial begin
        int len;
        bit err;
        clk = 1'b0;
        rst = 1'b1;
        in_tdata = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        out_tready = 1'b0;
        ready_random = 1'b0;
        data_seed = SEED;
        rdy_seed = SEED ^ 32'h5a5a_5a5a;
        exp_good = 0;
        exp_bad = 0;
        exp_drop = 0;
        test_num = 0;
        err_mark = 0;
        wait_cycles(2);
        rst = 1'b0;
        out_tready = 1'b1;

        // output flows freely, so nothing builds up in the store
        for (int i = 0; i < T1_FRAMES; i++) begin
            data_seed = next_rand(data_seed);
            run_frame(MIN_FRAME_LEN + data_seed[30:16] % 55, 1'b0, 0);
        end
        finish_test("good frames in order");

        for (int i = 0; i < T2_ERR_FRAMES; i++) begin
            data_seed = next_rand(data_seed);
            run_frame(MIN_FRAME_LEN + data_seed[30:16] % 55, 1'b1, 0);
        end
        run_frame(1, 1'b0, 0);
        run_frame(60, 1'b0, 0);
        finish_test("bad frames rejected");

        run_frame(70, 1'b0, 0);
        finish_test("oversize frame dropped");

        // stalled output, queue size equals committed words
        out_tready = 1'b0;
        run_frame(30, 1'b0, scb_i.exp_q.size());
        run_frame(30, 1'b0, scb_i.exp_q.size());
        run_frame(20, 1'b0, scb_i.exp_q.size());
        wait_cycles(8);
        out_tready = 1'b1;
        finish_test("drop when full");

        ready_random = 1'b1;
        for (int i = 0; i < T5_FRAMES; i++) begin
            data_seed = next_rand(data_seed);
            len = 1 + data_seed[30:16] % 72;
            err = data_seed[20] & data_seed[21];
            // keep clear of the fill boundary
            if (len > FIFO_DEPTH - 3 && len < FIFO_DEPTH + 3) begin
                len = 70;
            end
            // queue size bounds the store fill from above
            if (len <= FIFO_DEPTH - 3) begin
                while (scb_i.exp_q.size() + len > FIFO_DEPTH - 3) begin
                    wait_cycles(1);
                end
            end
            run_frame(len, err, scb_i.exp_q.size());
        end
        ready_random = 1'b0;
        out_tready = 1'b1;
        finish_test("random mix with back-pressure");

        $display("tests %0d, output beats %0d, errors %0d",
                 test_num, scb_i.beat_count, error_total());
        if (error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles, expected output never completed",
                 WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* tb/frame_scoreboard.sv */
// output checker; expected words are pushed by the testbench, beats sampled on the falling edge
`timescale 1ns/10ps

module frame_scoreboard
    import frame_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  in_tready,
    input logic [DATA_WIDTH-1:0] out_tdata,
    input logic                  out_tvalid,
    input logic                  out_tready,
    input logic                  out_tlast,
    input logic [STAT_WIDTH-1:0] good_frames,
    input logic [STAT_WIDTH-1:0] bad_frames,
    input logic [STAT_WIDTH-1:0] dropped_frames
);

    // expected {last, data} in output order
    logic [DATA_WIDTH:0] exp_q [$];
    int                  err_count = 0;
    int                  beat_count = 0;

    // mid-cycle sample, transfer happens on the next rising edge
    always @(negedge clk) begin
        logic [DATA_WIDTH:0] exp_word;
        // store never stalls, so the input side stays ready
        if (!rst && !in_tready) begin
            $display("FAILED t=%0t: in_tready low, input stream stalled", $time);
            err_count++;
        end
        if (!rst && out_tvalid && out_tready) begin
            if (exp_q.size() == 0) begin
                $display("FAILED t=%0t: unexpected output beat, data %02h last %0b",
                         $time, out_tdata, out_tlast);
                err_count++;
            end else begin
                exp_word = exp_q.pop_front();
                beat_count++;
                if ({out_tlast, out_tdata} !== exp_word) begin
                    $display("FAILED t=%0t: output beat %02h last %0b, expected %02h last %0b",
                             $time, out_tdata, out_tlast,
                             exp_word[DATA_WIDTH-1:0], exp_word[DATA_WIDTH]);
                    err_count++;
                end
            end
        end
    end

    // one counter against its expected value
    task automatic compare_count(input string name, input logic [STAT_WIDTH-1:0] actual,
                                 input int expected);
        if (actual !== STAT_WIDTH'(expected)) begin
            $display("FAILED t=%0t: %s is %0d, expected %0d", $time, name, actual, expected);
            err_count++;
        end
    endtask

    // called by the testbench once a test has drained
    task automatic check_counters(input int good, input int bad, input int drop);
        compare_count("good_frames", good_frames, good);
        compare_count("bad_frames", bad_frames, bad);
        compare_count("dropped_frames", dropped_frames, drop);
    endtask

endmodule

/* tb/frame_store_props.sv */
// frame_store assertions; the wr_ptr port expects the store's internal committed pointer
`timescale 1ns/10ps

module frame_store_props
    import frame_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic [DATA_WIDTH-1:0] out_tdata,
    input logic                  out_tvalid,
    input logic                  out_tready,
    input logic                  out_tlast,
    input logic                  frame_commit,
    input logic                  frame_reject,
    input logic                  frame_drop,
    input logic [ADDR_WIDTH:0]   wr_ptr
);

    // count of failed assertions
    int                  fail_count = 0;
    // words taken at the output since reset, same wrap as wr_ptr
    logic [ADDR_WIDTH:0] sent_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sent_cnt <= '0;
        end else if (out_tvalid && out_tready) begin
            sent_cnt <= sent_cnt + 1'b1;
        end
    end

    // output word frozen while stalled
    hold_under_stall_a: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
        else begin
            $error("output changed while stalled");
            fail_count++;
        end

    // one status pulse per last beat at most
    // committed pointer moves only after a commit
    one_status_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({frame_commit, frame_reject, frame_drop}) &&
        ((wr_ptr != $past(wr_ptr)) == $past(frame_commit)))
        else begin
            $error("status pulses disagree with committed pointer");
            fail_count++;
        end

    // every committed word already taken, nothing left to offer
    valid_needs_word_a: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr == sent_cnt) |-> !out_tvalid)
        else begin
            $error("output valid without committed word");
            fail_count++;
        end

endmodule

/* verilog/axis_if.sv */
// byte-wide AXI4-Stream link without keep; tuser is only meaningful on the tlast beat
`timescale 1ns/10ps

interface axis_if
    import frame_pkg::*;
();

    logic [DATA_WIDTH-1:0] tdata;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    // error flag, sampled on last beat only
    logic                  tuser;

    // source side, holds payload while tvalid and not tready
    modport src (output tdata, output tvalid, output tlast, output tuser, input tready);

    // sink side
    modport dst (input tdata, input tvalid, input tlast, input tuser, output tready);

endinterface

/* verilog/frame_buffer_top.sv */
// packet buffer top; output carries good frames only, so there is no output tuser
`timescale 1ns/10ps

module frame_buffer_top
    import frame_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // input stream, tuser flags a source error on tlast
    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,

    // output stream, whole committed frames
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,

    // frame counters
    output logic [STAT_WIDTH-1:0] good_frames,
    output logic [STAT_WIDTH-1:0] bad_frames,
    output logic [STAT_WIDTH-1:0] dropped_frames
);

    // store status toward statistics
    logic frame_commit;
    logic frame_reject;
    logic frame_drop;

    // checker to store link
    axis_if chk_to_store ();

    // length check, marks bad frames
    frame_len_check chk_i (
        .clk       (clk),
        .rst       (rst),
        .in_tdata  (in_tdata),
        .in_tvalid (in_tvalid),
        .in_tready (in_tready),
        .in_tlast  (in_tlast),
        .in_tuser  (in_tuser),
        .m         (chk_to_store.src)
    );

    // frame FIFO
    frame_store store_i (
        .clk          (clk),
        .rst          (rst),
        .s            (chk_to_store.dst),
        .out_tdata    (out_tdata),
        .out_tvalid   (out_tvalid),
        .out_tready   (out_tready),
        .out_tlast    (out_tlast),
        .frame_commit (frame_commit),
        .frame_reject (frame_reject),
        .frame_drop   (frame_drop)
    );

    // counters
    frame_stats stats_i (
        .clk            (clk),
        .rst            (rst),
        .frame_commit   (frame_commit),
        .frame_reject   (frame_reject),
        .frame_drop     (frame_drop),
        .good_frames    (good_frames),
        .bad_frames     (bad_frames),
        .dropped_frames (dropped_frames)
    );

endmodule

/* verilog/frame_len_check.sv */
// one-entry register stage; marks bad frames in tuser on tlast, length saturates at 127 beats
`timescale 1ns/10ps

module frame_len_check
    import frame_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,
    axis_if.src                   m
);

    len_state_t           state;
    // beats accepted so far in current frame
    logic [LEN_WIDTH-1:0] len_cnt;
    logic [LEN_WIDTH-1:0] len_base;
    // length including the beat now at the input
    logic [LEN_WIDTH-1:0] cur_len;
    logic                 accept;
    logic                 len_bad;

    // register empty or draining this cycle
    assign in_tready = ~m.tvalid | m.tready;
    assign accept    = in_tvalid & in_tready;

    // first beat of a frame counts from zero
    assign len_base = (state == LEN_IDLE) ? '0 : len_cnt;

    // saturating increment
    assign cur_len = (&len_base) ? len_base : len_base + 1'b1;

    // outside the good length window
    assign len_bad = (cur_len < LEN_WIDTH'(MIN_FRAME_LEN)) ||
                     (cur_len > LEN_WIDTH'(MAX_FRAME_LEN));

    // frame tracking FSM, advances only on accepted beats
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= LEN_IDLE;
            len_cnt <= '0;
        end else if (accept) begin
            if (in_tlast) begin
                // frame done, back to idle
                state   <= LEN_IDLE;
            end else begin
                state   <= LEN_IN_FRAME;
                len_cnt <= cur_len;
            end
        end
    end

    // output valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m.tvalid <= 1'b0;
        end else if (accept) begin
            m.tvalid <= 1'b1;
        end else if (m.tready) begin
            // beat taken, nothing new behind it
            m.tvalid <= 1'b0;
        end
    end

    // payload register
    // holds while stalled since accept is low then
    always_ff @(posedge clk) begin
        if (accept) begin
            m.tdata <= in_tdata;
            m.tlast <= in_tlast;
            // source error or bad length, last beat only
            m.tuser <= in_tlast & (in_tuser | len_bad);
        end
    end

endmodule

/* verilog/frame_pkg.sv */
// sizes and limits for the 8-bit frame buffer only; store depth must stay a power of two

package frame_pkg;

    // stream width, bytes only
    localparam int DATA_WIDTH = 8;

    // store geometry
    localparam int ADDR_WIDTH = 6;
    localparam int FIFO_DEPTH = 1 << ADDR_WIDTH;

    // good frame length window, in beats
    localparam int MIN_FRAME_LEN = 2;
    localparam int MAX_FRAME_LEN = 56;

    // beat counter width
    // saturates at 127, well above MAX_FRAME_LEN and FIFO_DEPTH
    localparam int LEN_WIDTH = 7;

    // statistics counter width, saturating
    localparam int STAT_WIDTH = 16;

    // checker FSM
    // idle waits for first beat, in-frame runs until tlast
    typedef enum logic [0:0] {
        LEN_IDLE,
        LEN_IN_FRAME
    } len_state_t;

endpackage

/* verilog/frame_stats.sv */
// good, bad and dropped frame counters; they saturate and clear only on reset
`timescale 1ns/10ps

module frame_stats
    import frame_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_commit,
    input  logic                  frame_reject,
    input  logic                  frame_drop,
    output logic [STAT_WIDTH-1:0] good_frames,
    output logic [STAT_WIDTH-1:0] bad_frames,
    output logic [STAT_WIDTH-1:0] dropped_frames
);

    // index 0 good, 1 bad, 2 dropped
    logic [2:0]            pulse;
    logic [STAT_WIDTH-1:0] cnt [3];

    assign pulse = {frame_drop, frame_reject, frame_commit};

    // saturating increment
    function automatic logic [STAT_WIDTH-1:0] sat_inc(input logic [STAT_WIDTH-1:0] val);
        if (&val) begin
            return val;
        end
        return val + 1'b1;
    endfunction

    // same counter logic for all three
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (pulse[i]) begin
                    cnt[i] <= sat_inc(cnt[i]);
                end
            end
        end
    end

    assign good_frames    = cnt[0];
    assign bad_frames     = cnt[1];
    assign dropped_frames = cnt[2];

endmodule

/* verilog/frame_store.sv */
// frame FIFO with drop-when-full always on; input never stalls, frames over 64 beats are dropped
`timescale 1ns/10ps

module frame_store
    import frame_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    axis_if.dst                   s,
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic                  frame_commit,
    output logic                  frame_reject,
    output logic                  frame_drop
);

    // pointers carry one extra wrap bit
    // committed frame end
    logic [ADDR_WIDTH:0] wr_ptr;
    // write position inside the frame in progress
    logic [ADDR_WIDTH:0] wr_ptr_cur;
    logic [ADDR_WIDTH:0] rd_ptr;

    // frame overflowed, discard rest of it
    logic drop_frame;

    // {last, data} per word
    logic [DATA_WIDTH:0] mem [FIFO_DEPTH];
    logic [DATA_WIDTH:0] out_word;

    logic full;
    logic empty;
    logic overflow;
    logic write;
    logic read;
    logic last_beat;

    // no room left between write head and reader
    // also covers a single frame reaching FIFO_DEPTH since rd_ptr never passes wr_ptr
    assign full = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    // only committed words are visible to the reader
    assign empty = (wr_ptr == rd_ptr);

    // always ready, overflow handled by dropping
    assign s.tready = 1'b1;

    assign write     = s.tvalid & s.tready;
    assign overflow  = full | drop_frame;
    assign last_beat = write & s.tlast;

    // load output register when it is free or draining
    assign read = (out_tready | ~out_tvalid) & ~empty;

    // status pulses, one per last beat, mutually exclusive
    assign frame_drop   = last_beat & overflow;
    assign frame_reject = last_beat & ~overflow & s.tuser;
    assign frame_commit = last_beat & ~overflow & ~s.tuser;

    // memory write
    always_ff @(posedge clk) begin
        if (write && !overflow) begin
            mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= {s.tlast, s.tdata};
        end
    end

    // write side pointers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            wr_ptr_cur <= '0;
            drop_frame <= 1'b0;
        end else if (write) begin
            if (overflow) begin
                // stop writing, hold pointer until tlast
                drop_frame <= 1'b1;
                if (s.tlast) begin
                    // discard partial frame
                    wr_ptr_cur <= wr_ptr;
                    drop_frame <= 1'b0;
                end
            end else begin
                wr_ptr_cur <= wr_ptr_cur + 1'b1;
                if (s.tlast) begin
                    if (s.tuser) begin
                        // bad frame, roll back
                        wr_ptr_cur <= wr_ptr;
                    end else begin
                        // good frame, publish to reader
                        wr_ptr <= wr_ptr_cur + 1'b1;
                    end
                end
            end
        end
    end

    // read pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // output word register
    always_ff @(posedge clk) begin
        if (read) begin
            out_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // output valid
    // held under back-pressure, else follows store occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_tvalid <= 1'b0;
        end else if (out_tready || !out_tvalid) begin
            out_tvalid <= ~empty;
        end
    end

    assign out_tlast = out_word[DATA_WIDTH];
    assign out_tdata = out_word[DATA_WIDTH-1:0];

endmodule
